// File: heapConfigPkg.sv
/*
  Fixed APB widths and the default heap geometry.
  The element width must not exceed the 32 bit APB word.
*/
package heapConfigPkg;

  // --------------------
  // APB bus
  // --------------------
  localparam int apbAddrBits = 8;                   // Byte address width
  localparam int apbDataBits = 32;                  // Read and write data width

  typedef logic [apbAddrBits-1:0] apbAddr_t;        // APB byte address
  typedef logic [apbDataBits-1:0] apbWord_t;        // APB data word

  // --------------------
  // Heap geometry
  // --------------------
  localparam int defaultArrayBits = 2;              // Four arrays
  localparam int defaultIndexBits = 2;              // Four elements per array
  localparam int defaultDataBits  = 16;             // Element width, 32 at most

endpackage

// File: heapOpPkg.sv
/*
  Heap opcodes, error codes and APB register offsets.
  Opcode values 0 and 15 are unused and report errBadOp.
*/
package heapOpPkg;

  typedef enum logic [3:0] {
    opClear    = 4'd1,                              // Forget every array
    opWrite    = 4'd2,                              // Store, may grow the size
    opRead     = 4'd3,
    opSize     = 4'd4,
    opPush     = 4'd5,
    opPop      = 4'd6,
    opAlloc    = 4'd7,                              // Reuses the last freed array first
    opFree     = 4'd8,
    opAdd      = 4'd9,
    opAddAfter = 4'd10,                             // Returns the old element
    opSub      = 4'd11,
    opAnd      = 4'd12,
    opOr       = 4'd13,
    opXor      = 4'd14
  } heapOp_t;

  typedef enum logic [3:0] {
    errNone         = 4'd0,
    errNotAllocated = 4'd1,
    errFreed        = 4'd2,
    errOutOfBounds  = 4'd3,
    errFull         = 4'd4,                         // Push on a full array
    errEmpty        = 4'd5,                         // Pop on an empty array
    errOutOfMemory  = 4'd6,
    errBadOp        = 4'd7
  } heapErr_t;

  localparam heapConfigPkg::apbAddr_t regArray   = 8'h00;
  localparam heapConfigPkg::apbAddr_t regIndex   = 8'h04;
  localparam heapConfigPkg::apbAddr_t regData    = 8'h08;
  localparam heapConfigPkg::apbAddr_t regCommand = 8'h0C;  // Write stalls until done
  localparam heapConfigPkg::apbAddr_t regResult  = 8'h10;
  localparam heapConfigPkg::apbAddr_t regError   = 8'h14;

endpackage

// File: heapApbDecode.sv
/*
  APB slave front end. Operand registers are write-only.
  A COMMAND write holds apbReady low until the heap reports done,
  operand writes during that wait are ignored.
*/
`timescale 1ns/100ps

module heapApbDecode #(
  parameter int arrayBits = 2,
  parameter int indexBits = 2,
  parameter int dataBits  = 16
) (
  input  logic                     clock,
  input  logic                     resetN,
  input  logic                     apbSel,
  input  logic                     apbEnable,
  input  logic                     apbWrite,
  input  heapConfigPkg::apbAddr_t  apbAddr,
  input  heapConfigPkg::apbWord_t  apbWdata,
  input  logic                     opDone,
  input  logic                     opError,
  output logic                     apbReady,
  output logic                     apbSlvErr,
  output logic                     opStart,
  output heapOpPkg::heapOp_t       opCode,
  output logic [arrayBits-1:0]     opArray,
  output logic [indexBits-1:0]     opIndex,
  output logic [dataBits-1:0]      opData
);

  logic busy;                                       // Command in flight
  logic writeAccess;
  logic cmdAccess;

  assign writeAccess = apbSel && apbEnable && apbWrite;
  assign cmdAccess   = writeAccess && (apbAddr == heapOpPkg::regCommand);

  assign apbReady  = busy ? opDone : !cmdAccess;    // Low from first access cycle
  assign apbSlvErr = busy && opDone && opError;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      busy    <= 1'b0;
      opStart <= 1'b0;
    end else begin
      opStart <= cmdAccess && !busy;                // One cycle, after the first access
      if (cmdAccess && !busy) begin
        busy <= 1'b1;
      end else if (opDone) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (writeAccess && !busy) begin
      case (apbAddr)
        heapOpPkg::regArray:   opArray <= apbWdata[arrayBits-1:0];
        heapOpPkg::regIndex:   opIndex <= apbWdata[indexBits-1:0];
        heapOpPkg::regData:    opData  <= apbWdata[dataBits-1:0];
        heapOpPkg::regCommand: opCode  <= heapOpPkg::heapOp_t'(apbWdata[3:0]);
        default: ;                                  // RESULT, ERROR and holes
      endcase
    end
  end

endmodule

// File: heapAllocator.sv
/*
  Array bookkeeping. Arrays are handed out in order, freed ones come back
  last-freed-first. Status outputs show the state before this cycle's request.
*/
`timescale 1ns/100ps

module heapAllocator #(
  parameter int arrayBits = 2
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 allocReq,
  input  logic                 freeReq,
  input  logic                 clearReq,
  input  logic [arrayBits-1:0] checkArray,
  output logic                 arrayLive,
  output logic                 arrayFreed,
  output logic [arrayBits-1:0] allocArray,
  output logic                 allocOk
);

  localparam int numArrays = 2 ** arrayBits;

  typedef logic [arrayBits-1:0] array_t;
  typedef logic [arrayBits:0]   count_t;

  array_t               freeStack [numArrays];      // LIFO of freed arrays
  count_t               stackTop;
  count_t               allocCount;                 // Arrays handed out so far
  logic [numArrays-1:0] live;
  logic [numArrays-1:0] freed;
  array_t               popArray;
  logic                 doFree;

  assign popArray = freeStack[array_t'(stackTop - 1'b1)];
  assign doFree   = freeReq && !clearReq && live[checkArray];  // Double free is ignored

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      stackTop   <= '0;
      allocCount <= '0;
      live       <= '0;
      freed      <= '0;
      arrayLive  <= 1'b0;
      arrayFreed <= 1'b0;
      allocArray <= '0;
      allocOk    <= 1'b0;
    end else begin
      arrayLive  <= live[checkArray];
      arrayFreed <= freed[checkArray];
      allocOk    <= 1'b0;
      if (clearReq) begin
        stackTop   <= '0;
        allocCount <= '0;
        live       <= '0;
        freed      <= '0;
      end else if (allocReq) begin
        if (stackTop != '0) begin                   // Reuse a freed array
          allocArray      <= popArray;
          live[popArray]  <= 1'b1;
          freed[popArray] <= 1'b0;
          stackTop        <= stackTop - 1'b1;
          allocOk         <= 1'b1;
        end else if (allocCount < count_t'(numArrays)) begin
          allocArray                 <= array_t'(allocCount);
          live[array_t'(allocCount)] <= 1'b1;
          allocCount                 <= allocCount + 1'b1;
          allocOk                    <= 1'b1;
        end
      end else if (doFree) begin
        live[checkArray]  <= 1'b0;
        freed[checkArray] <= 1'b1;
        stackTop          <= stackTop + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (doFree) begin
      freeStack[array_t'(stackTop)] <= checkArray;  // Never overflows, only live arrays
    end
  end

endmodule

// File: heapExecute.sv
/*
  Operation datapath. Fetch on opStart, check and commit one cycle later,
  opDone follows two cycles after opStart. A failed check changes nothing.
*/
`timescale 1ns/100ps

module heapExecute #(
  parameter int arrayBits = 2,
  parameter int indexBits = 2,
  parameter int dataBits  = 16
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 opStart,
  input  heapOpPkg::heapOp_t   opCode,
  input  logic [arrayBits-1:0] opArray,
  input  logic [indexBits-1:0] opIndex,
  input  logic [dataBits-1:0]  opData,
  input  logic                 arrayLive,
  input  logic                 arrayFreed,
  input  logic [arrayBits-1:0] allocArray,
  input  logic                 allocOk,
  output logic                 allocReq,
  output logic                 freeReq,
  output logic                 clearReq,
  output logic [arrayBits-1:0] checkArray,
  output logic                 opDone,
  output logic                 opError,
  output logic [dataBits-1:0]  opResult,
  output heapOpPkg::heapErr_t  opErrCode
);

  localparam int numArrays = 2 ** arrayBits;
  localparam int arrayLen  = 2 ** indexBits;

  typedef logic [dataBits-1:0]  data_t;
  typedef logic [indexBits-1:0] idx_t;
  typedef logic [indexBits:0]   size_t;             // Counts 0 to arrayLen
  typedef enum logic {stFetch, stCommit} state_t;

  state_t              state;
  data_t               mem [numArrays][arrayLen];
  size_t               sizes [numArrays];
  data_t               elemQ;                       // Fetched element
  size_t               sizeQ;                       // Fetched size
  logic                launch;
  idx_t                fetchIndex;
  data_t               aluOut;
  heapOpPkg::heapErr_t liveErr;
  heapOpPkg::heapErr_t boundsErr;
  heapOpPkg::heapErr_t errNext;
  data_t               resultNext;
  logic                memWrite;
  idx_t                memIndex;
  logic                sizeWrite;
  size_t               sizeNext;
  logic [arrayBits-1:0] sizeArray;

  assign launch     = opStart && (state == stFetch);
  assign checkArray = opArray;
  assign allocReq   = launch && (opCode == heapOpPkg::opAlloc);
  assign freeReq    = launch && (opCode == heapOpPkg::opFree);
  assign clearReq   = launch && (opCode == heapOpPkg::opClear);
  assign fetchIndex = (opCode == heapOpPkg::opPop) ? idx_t'(sizes[opArray] - 1'b1) : opIndex;

  assign liveErr   = arrayLive ? heapOpPkg::errNone
                   : (arrayFreed ? heapOpPkg::errFreed : heapOpPkg::errNotAllocated);
  assign boundsErr = (liveErr != heapOpPkg::errNone) ? liveErr
                   : ((size_t'(opIndex) >= sizeQ) ? heapOpPkg::errOutOfBounds : heapOpPkg::errNone);
  assign sizeArray = (opCode == heapOpPkg::opAlloc) ? allocArray : opArray;

  always_comb begin
    case (opCode)
      heapOpPkg::opAdd, heapOpPkg::opAddAfter: aluOut = elemQ + opData;
      heapOpPkg::opSub: aluOut = elemQ - opData;
      heapOpPkg::opAnd: aluOut = elemQ & opData;
      heapOpPkg::opOr:  aluOut = elemQ | opData;
      heapOpPkg::opXor: aluOut = elemQ ^ opData;
      default:          aluOut = opData;            // Write and push store the operand
    endcase
  end

  // --------------------
  // Check and commit
  // --------------------
  always_comb begin
    errNext    = heapOpPkg::errNone;
    resultNext = aluOut;
    memWrite   = 1'b0;
    memIndex   = opIndex;
    sizeWrite  = 1'b0;
    sizeNext   = sizeQ;
    case (opCode)
      heapOpPkg::opClear: resultNext = '0;
      heapOpPkg::opAlloc: begin
        resultNext = data_t'(allocArray);
        sizeWrite  = allocOk;                       // New array starts empty
        sizeNext   = '0;
        if (!allocOk) begin
          errNext = heapOpPkg::errOutOfMemory;
        end
      end
      heapOpPkg::opFree: begin
        errNext    = liveErr;
        resultNext = data_t'(opArray);
      end
      heapOpPkg::opWrite: begin
        errNext  = liveErr;
        memWrite = 1'b1;
        if (size_t'(opIndex) >= sizeQ) begin
          sizeWrite = 1'b1;
          sizeNext  = size_t'(opIndex) + 1'b1;
        end
      end
      heapOpPkg::opRead: begin
        errNext    = boundsErr;
        resultNext = elemQ;
      end
      heapOpPkg::opSize: begin
        errNext    = liveErr;
        resultNext = data_t'(sizeQ);
      end
      heapOpPkg::opPush: begin
        errNext = liveErr;
        if (liveErr == heapOpPkg::errNone && sizeQ == size_t'(arrayLen)) begin
          errNext = heapOpPkg::errFull;
        end
        memWrite  = 1'b1;
        memIndex  = idx_t'(sizeQ);
        sizeWrite = 1'b1;
        sizeNext  = sizeQ + 1'b1;
      end
      heapOpPkg::opPop: begin
        errNext = liveErr;
        if (liveErr == heapOpPkg::errNone && sizeQ == '0) begin
          errNext = heapOpPkg::errEmpty;
        end
        resultNext = elemQ;
        sizeWrite  = 1'b1;
        sizeNext   = sizeQ - 1'b1;
      end
      heapOpPkg::opAdd, heapOpPkg::opAddAfter, heapOpPkg::opSub,
      heapOpPkg::opAnd, heapOpPkg::opOr, heapOpPkg::opXor: begin
        errNext  = boundsErr;
        memWrite = 1'b1;
        if (opCode == heapOpPkg::opAddAfter) begin
          resultNext = elemQ;
        end
      end
      default: errNext = heapOpPkg::errBadOp;
    endcase
    if (errNext != heapOpPkg::errNone) begin        // Failed check leaves state alone
      resultNext = '0;
      memWrite   = 1'b0;
      sizeWrite  = 1'b0;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state   <= stFetch;
      opDone  <= 1'b0;
      opError <= 1'b0;
    end else begin
      opDone  <= 1'b0;
      opError <= 1'b0;
      if (launch) begin
        state <= stCommit;
      end else if (state == stCommit) begin
        state   <= stFetch;
        opDone  <= 1'b1;
        opError <= (errNext != heapOpPkg::errNone);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (launch) begin
      elemQ <= mem[opArray][fetchIndex];
      sizeQ <= sizes[opArray];
    end
    if (state == stCommit) begin
      opResult  <= resultNext;
      opErrCode <= errNext;
      if (memWrite) begin
        mem[opArray][memIndex] <= aluOut;
      end
      if (sizeWrite) begin
        sizes[sizeArray] <= sizeNext;
      end
    end
  end

endmodule

// File: heapResponse.sv
/*
  Result and error holding registers, updated on opDone.
  Values read back zero-extended, every other offset reads zero.
*/
`timescale 1ns/100ps

module heapResponse #(
  parameter int dataBits = 16
) (
  input  logic                    clock,
  input  logic                    resetN,
  input  logic                    opDone,
  input  logic [dataBits-1:0]     opResult,
  input  heapOpPkg::heapErr_t     opErrCode,
  input  logic                    apbSel,
  input  logic                    apbWrite,
  input  heapConfigPkg::apbAddr_t apbAddr,
  output heapConfigPkg::apbWord_t apbRdata
);

  logic [dataBits-1:0] resultQ;
  heapOpPkg::heapErr_t errQ;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      resultQ <= '0;
      errQ    <= heapOpPkg::errNone;
    end else if (opDone) begin
      resultQ <= opResult;
      errQ    <= opErrCode;
    end
  end

  always_comb begin
    apbRdata = '0;
    if (apbSel && !apbWrite) begin
      case (apbAddr)
        heapOpPkg::regResult: apbRdata = heapConfigPkg::apbWord_t'(resultQ);
        heapOpPkg::regError:  apbRdata = heapConfigPkg::apbWord_t'(errQ);
        default:              apbRdata = '0;        // Operands are write-only
      endcase
    end
  end

endmodule

// File: heapTop.sv
/*
  Array heap behind an APB slave port.
  Geometry comes from the configuration package defaults.
*/
`timescale 1ns/100ps

module heapTop #(
  parameter int arrayBits = heapConfigPkg::defaultArrayBits,
  parameter int indexBits = heapConfigPkg::defaultIndexBits,
  parameter int dataBits  = heapConfigPkg::defaultDataBits
) (
  input  logic                    clock,
  input  logic                    resetN,
  input  logic                    apbSel,
  input  logic                    apbEnable,
  input  logic                    apbWrite,
  input  heapConfigPkg::apbAddr_t apbAddr,
  input  heapConfigPkg::apbWord_t apbWdata,
  output heapConfigPkg::apbWord_t apbRdata,
  output logic                    apbReady,
  output logic                    apbSlvErr
);

  logic                 opStart;
  logic                 opDone;
  logic                 opError;
  heapOpPkg::heapOp_t   opCode;
  logic [arrayBits-1:0] opArray;
  logic [indexBits-1:0] opIndex;
  logic [dataBits-1:0]  opData;
  logic [dataBits-1:0]  opResult;
  heapOpPkg::heapErr_t  opErrCode;
  logic                 allocReq;
  logic                 freeReq;
  logic                 clearReq;
  logic [arrayBits-1:0] checkArray;
  logic                 arrayLive;
  logic                 arrayFreed;
  logic [arrayBits-1:0] allocArray;
  logic                 allocOk;

  heapApbDecode #(
    .arrayBits(arrayBits),
    .indexBits(indexBits),
    .dataBits(dataBits)
  ) u_heapApbDecode (
    .clock(clock), .resetN(resetN),
    .apbSel(apbSel), .apbEnable(apbEnable), .apbWrite(apbWrite),
    .apbAddr(apbAddr), .apbWdata(apbWdata),
    .opDone(opDone), .opError(opError),
    .apbReady(apbReady), .apbSlvErr(apbSlvErr),
    .opStart(opStart), .opCode(opCode),
    .opArray(opArray), .opIndex(opIndex), .opData(opData)
  );

  heapExecute #(
    .arrayBits(arrayBits),
    .indexBits(indexBits),
    .dataBits(dataBits)
  ) u_heapExecute (
    .clock(clock), .resetN(resetN),
    .opStart(opStart), .opCode(opCode),
    .opArray(opArray), .opIndex(opIndex), .opData(opData),
    .arrayLive(arrayLive), .arrayFreed(arrayFreed),
    .allocArray(allocArray), .allocOk(allocOk),
    .allocReq(allocReq), .freeReq(freeReq), .clearReq(clearReq),
    .checkArray(checkArray),
    .opDone(opDone), .opError(opError),
    .opResult(opResult), .opErrCode(opErrCode)
  );

  heapAllocator #(
    .arrayBits(arrayBits)
  ) u_heapAllocator (
    .clock(clock), .resetN(resetN),
    .allocReq(allocReq), .freeReq(freeReq), .clearReq(clearReq),
    .checkArray(checkArray),
    .arrayLive(arrayLive), .arrayFreed(arrayFreed),
    .allocArray(allocArray), .allocOk(allocOk)
  );

  heapResponse #(
    .dataBits(dataBits)
  ) u_heapResponse (
    .clock(clock), .resetN(resetN),
    .opDone(opDone), .opResult(opResult), .opErrCode(opErrCode),
    .apbSel(apbSel), .apbWrite(apbWrite), .apbAddr(apbAddr),
    .apbRdata(apbRdata)
  );

endmodule

// File: heapTbTasks.svh
/*
  Reference model and directed tests for the heap testbench.
  Tests only read back elements written since the array was allocated.
*/
`ifndef HEAP_TB_TASKS_SVH
`define HEAP_TB_TASKS_SVH

  // --------------------
  // Reference model
  // --------------------
  logic  modelLive [numArrays];
  logic  modelFreed [numArrays];
  int    modelStack [$];                            // Freed arrays, last one at the back
  int    modelNextNew;
  int    modelSize [numArrays];
  elem_t modelMem [numArrays][arrayLen];

  task automatic resetModel();
    for (int a = 0; a < numArrays; a++) begin
      modelLive[a]  = 1'b0;
      modelFreed[a] = 1'b0;
      modelSize[a]  = 0;
    end
    modelStack.delete();
    modelNextNew = 0;
  endtask

  task automatic predict(input logic [3:0] op, input int arr, input int idx, input elem_t data,
                         output elem_t expRes, output logic [3:0] expErr);
    logic [3:0] liveErr;
    elem_t      oldVal;
    elem_t      newVal;
    int         pick;
    expRes  = '0;
    expErr  = heapOpPkg::errNone;
    liveErr = modelLive[arr] ? heapOpPkg::errNone
            : (modelFreed[arr] ? heapOpPkg::errFreed : heapOpPkg::errNotAllocated);
    oldVal  = modelMem[arr][idx];
    pick    = -1;
    case (op)
      heapOpPkg::opClear: resetModel();
      heapOpPkg::opAlloc: begin
        if (modelStack.size() > 0) begin
          pick = modelStack.pop_back();             // Last freed comes back first
        end else if (modelNextNew < numArrays) begin
          pick = modelNextNew;
          modelNextNew++;
        end else begin
          expErr = heapOpPkg::errOutOfMemory;
        end
        if (pick >= 0) begin
          modelLive[pick]  = 1'b1;
          modelFreed[pick] = 1'b0;
          modelSize[pick]  = 0;
          expRes           = elem_t'(pick);
        end
      end
      heapOpPkg::opFree: begin
        expErr = liveErr;
        expRes = elem_t'(arr);
        if (liveErr == heapOpPkg::errNone) begin
          modelLive[arr]  = 1'b0;
          modelFreed[arr] = 1'b1;
          modelStack.push_back(arr);
        end
      end
      heapOpPkg::opWrite: begin
        expErr = liveErr;
        expRes = data;
        if (liveErr == heapOpPkg::errNone) begin
          modelMem[arr][idx] = data;
          if (modelSize[arr] < idx + 1) modelSize[arr] = idx + 1;
        end
      end
      heapOpPkg::opRead: begin
        expErr = liveErr;
        if (liveErr == heapOpPkg::errNone && idx >= modelSize[arr]) begin
          expErr = heapOpPkg::errOutOfBounds;
        end
        expRes = oldVal;
      end
      heapOpPkg::opSize: begin
        expErr = liveErr;
        expRes = elem_t'(modelSize[arr]);
      end
      heapOpPkg::opPush: begin
        expErr = liveErr;
        expRes = data;
        if (liveErr == heapOpPkg::errNone && modelSize[arr] == arrayLen) begin
          expErr = heapOpPkg::errFull;
        end else if (liveErr == heapOpPkg::errNone) begin
          modelMem[arr][modelSize[arr]] = data;
          modelSize[arr]++;
        end
      end
      heapOpPkg::opPop: begin
        expErr = liveErr;
        if (liveErr == heapOpPkg::errNone && modelSize[arr] == 0) begin
          expErr = heapOpPkg::errEmpty;
        end else if (liveErr == heapOpPkg::errNone) begin
          modelSize[arr]--;
          expRes = modelMem[arr][modelSize[arr]];
        end
      end
      heapOpPkg::opAdd, heapOpPkg::opAddAfter, heapOpPkg::opSub,
      heapOpPkg::opAnd, heapOpPkg::opOr, heapOpPkg::opXor: begin
        expErr = liveErr;
        if (liveErr == heapOpPkg::errNone && idx >= modelSize[arr]) begin
          expErr = heapOpPkg::errOutOfBounds;
        end
        case (op)
          heapOpPkg::opSub: newVal = oldVal - data;
          heapOpPkg::opAnd: newVal = oldVal & data;
          heapOpPkg::opOr:  newVal = oldVal | data;
          heapOpPkg::opXor: newVal = oldVal ^ data;
          default:          newVal = oldVal + data; // Wraps at the element width
        endcase
        expRes = (op == heapOpPkg::opAddAfter) ? oldVal : newVal;
        if (expErr == heapOpPkg::errNone) modelMem[arr][idx] = newVal;
      end
      default: expErr = heapOpPkg::errBadOp;
    endcase
  endtask

  // Loads the operands, issues the command and compares ERROR and RESULT
  task automatic runCommand(input logic [3:0] op, input int arr, input int idx, input elem_t data);
    elem_t                   expRes;
    logic [3:0]              expErr;
    heapConfigPkg::apbWord_t got;
    string                   ctx;
    ctx = $sformatf("op %0d array %0d index %0d", op, arr, idx);
    predict(op, arr, idx, data, expRes, expErr);
    writeReg(heapOpPkg::regArray, heapConfigPkg::apbWord_t'(arr));
    writeReg(heapOpPkg::regIndex, heapConfigPkg::apbWord_t'(idx));
    writeReg(heapOpPkg::regData, heapConfigPkg::apbWord_t'(data));
    writeReg(heapOpPkg::regCommand, heapConfigPkg::apbWord_t'(op));
    checkValue({ctx, " COMMAND wait cycles"}, heapConfigPkg::apbWord_t'(lastWaits),
               heapConfigPkg::apbWord_t'(cmdWaits));
    checkValue({ctx, " apbSlvErr"}, heapConfigPkg::apbWord_t'(lastSlvErr),
               heapConfigPkg::apbWord_t'(expErr != heapOpPkg::errNone));
    readReg(heapOpPkg::regError, got);
    checkValue({ctx, " ERROR"}, got, heapConfigPkg::apbWord_t'(expErr));
    if (expErr == heapOpPkg::errNone) begin
      readReg(heapOpPkg::regResult, got);
      checkValue({ctx, " RESULT"}, got, heapConfigPkg::apbWord_t'(expRes));
    end
  endtask

  function automatic elem_t randomElem();
    return elem_t'($random(seed));
  endfunction

  // --------------------
  // Directed tests
  // --------------------
  task automatic testResetTiming();
    heapConfigPkg::apbWord_t got;
    checkValue("apbReady after reset", heapConfigPkg::apbWord_t'(apbReady), 32'd1);
    checkValue("apbSlvErr after reset", heapConfigPkg::apbWord_t'(apbSlvErr), '0);
    readReg(heapOpPkg::regResult, got);
    checkValue("RESULT after reset", got, '0);
    readReg(heapOpPkg::regError, got);
    checkValue("ERROR after reset", got, '0);
    writeReg(heapOpPkg::regResult, 32'h1234);       // Ignored by the DUT
    readReg(heapOpPkg::regResult, got);
    checkValue("RESULT after write", got, '0);
    writeReg(heapOpPkg::regData, 32'h00ab);
    readReg(heapOpPkg::regData, got);
    checkValue("DATA read back", got, '0);          // Operands are write-only
    readReg(8'h18, got);
    checkValue("unknown offset read", got, '0);
  endtask

  task automatic testAllocClear();
    runCommand(heapOpPkg::opClear, 0, 0, '0);
    for (int i = 0; i < numArrays; i++) begin
      runCommand(heapOpPkg::opAlloc, 0, 0, '0);
    end
    runCommand(heapOpPkg::opAlloc, 0, 0, '0);      // Out of memory
  endtask

  task automatic testAccessChecks();
    runCommand(heapOpPkg::opClear, 0, 0, '0);
    runCommand(heapOpPkg::opAlloc, 0, 0, '0);
    runCommand(heapOpPkg::opAlloc, 0, 0, '0);
    runCommand(heapOpPkg::opRead, 2, 0, '0);       // Never allocated
    runCommand(heapOpPkg::opWrite, 0, 2, randomElem());
    runCommand(heapOpPkg::opSize, 0, 0, '0);
    runCommand(heapOpPkg::opWrite, 0, 0, randomElem());
    runCommand(heapOpPkg::opWrite, 0, 1, randomElem());
    runCommand(heapOpPkg::opSize, 0, 0, '0);
    for (int i = 0; i < 3; i++) begin
      runCommand(heapOpPkg::opRead, 0, i, '0);
    end
    runCommand(heapOpPkg::opRead, 0, 3, '0);       // Past the size
    runCommand(heapOpPkg::opAdd, 0, 3, randomElem());
    runCommand(heapOpPkg::opWrite, 0, 3, randomElem());
    runCommand(heapOpPkg::opRead, 0, 3, '0);
    runCommand(heapOpPkg::opFree, 1, 0, '0);
    runCommand(heapOpPkg::opRead, 1, 0, '0);
    runCommand(heapOpPkg::opWrite, 1, 0, randomElem());
    runCommand(heapOpPkg::opSize, 1, 0, '0);
  endtask

  task automatic testPushPop();
    runCommand(heapOpPkg::opClear, 0, 0, '0);
    runCommand(heapOpPkg::opAlloc, 0, 0, '0);
    runCommand(heapOpPkg::opPop, 0, 0, '0);        // Empty
    for (int i = 0; i < arrayLen; i++) begin
      runCommand(heapOpPkg::opPush, 0, 0, randomElem());
    end
    runCommand(heapOpPkg::opPush, 0, 0, randomElem());
    runCommand(heapOpPkg::opSize, 0, 0, '0);
    for (int i = 0; i < arrayLen; i++) begin
      runCommand(heapOpPkg::opPop, 0, 0, '0);
    end
    runCommand(heapOpPkg::opPop, 0, 0, '0);
    runCommand(heapOpPkg::opPush, 3, 0, randomElem());
  endtask

  task automatic testArithmetic();
    logic [3:0] aluOps [6];
    int         idx;
    aluOps = '{heapOpPkg::opAdd, heapOpPkg::opAddAfter, heapOpPkg::opSub,
               heapOpPkg::opAnd, heapOpPkg::opOr, heapOpPkg::opXor};
    runCommand(heapOpPkg::opClear, 0, 0, '0);
    runCommand(heapOpPkg::opAlloc, 0, 0, '0);
    for (int i = 0; i < arrayLen; i++) begin
      runCommand(heapOpPkg::opWrite, 0, i, randomElem());
    end
    for (int round = 0; round < 3; round++) begin
      for (int k = 0; k < 6; k++) begin
        idx = int'({$random(seed)} % arrayLen);
        runCommand(aluOps[k], 0, idx, randomElem());
      end
    end
    for (int i = 0; i < arrayLen; i++) begin
      runCommand(heapOpPkg::opRead, 0, i, '0);
    end
    runCommand(heapOpPkg::opAlloc, 0, 0, '0);
    runCommand(heapOpPkg::opWrite, 1, 0, 16'hffff);
    runCommand(heapOpPkg::opAdd, 1, 0, 16'h0002);  // Wraps around
    runCommand(heapOpPkg::opXor, 1, 1, randomElem());
  endtask

  task automatic testFreeReuse();
    runCommand(heapOpPkg::opClear, 0, 0, '0);
    for (int i = 0; i < 3; i++) begin
      runCommand(heapOpPkg::opAlloc, 0, 0, '0);
    end
    runCommand(heapOpPkg::opFree, 1, 0, '0);
    runCommand(heapOpPkg::opFree, 2, 0, '0);
    runCommand(heapOpPkg::opRead, 2, 0, '0);
    runCommand(heapOpPkg::opPush, 2, 0, randomElem());
    runCommand(heapOpPkg::opFree, 2, 0, '0);       // Double free
    runCommand(heapOpPkg::opFree, 3, 0, '0);
    for (int i = 0; i < 4; i++) begin
      runCommand(heapOpPkg::opAlloc, 0, 0, '0);    // 2, 1, 3, then none
    end
    runCommand(4'd0, 0, 0, '0);
    runCommand(4'd15, 0, 0, '0);
  endtask

`endif

// File: heapTb.sv
/*
  Directed testbench for the APB array heap at its default geometry.
  Inputs change on the falling edge, outputs are sampled 1 ns after it.
*/
`timescale 1ns/100ps

module heapTb;

  localparam int numArrays  = 2 ** heapConfigPkg::defaultArrayBits;
  localparam int arrayLen   = 2 ** heapConfigPkg::defaultIndexBits;
  localparam int dataBits   = heapConfigPkg::defaultDataBits;
  localparam int readyLimit = 20;                   // Cycles before a wait gives up
  localparam int cmdWaits   = 3;                    // apbReady low cycles per COMMAND

  typedef logic [dataBits-1:0] elem_t;

  logic                    clock;
  logic                    resetN;
  logic                    apbSel;
  logic                    apbEnable;
  logic                    apbWrite;
  heapConfigPkg::apbAddr_t apbAddr;
  heapConfigPkg::apbWord_t apbWdata;
  heapConfigPkg::apbWord_t apbRdata;
  logic                    apbReady;
  logic                    apbSlvErr;

  integer                  seed;
  int                      errorCount;
  int                      checkCount;
  logic                    timedOut;                // Set once, later accesses are skipped
  int                      lastWaits;
  logic                    lastSlvErr;
  heapConfigPkg::apbWord_t lastRdata;

  heapTop u_heapTop (
    .clock(clock), .resetN(resetN),
    .apbSel(apbSel), .apbEnable(apbEnable), .apbWrite(apbWrite),
    .apbAddr(apbAddr), .apbWdata(apbWdata),
    .apbRdata(apbRdata), .apbReady(apbReady), .apbSlvErr(apbSlvErr)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic checkValue(input string what, input heapConfigPkg::apbWord_t got,
                            input heapConfigPkg::apbWord_t exp);
    if (!timedOut) begin
      checkCount++;
      if (got !== exp) begin
        errorCount++;
        $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
      end
    end
  endtask

  // --------------------
  // APB transfers
  // --------------------
  task automatic busTransfer(input logic write, input heapConfigPkg::apbAddr_t addr,
                             input heapConfigPkg::apbWord_t wdata);
    int waits;
    waits = 0;
    if (!timedOut) begin
      @(negedge clock);
      apbSel    = 1'b1;                             // Setup cycle
      apbEnable = 1'b0;
      apbWrite  = write;
      apbAddr   = addr;
      apbWdata  = wdata;
      @(negedge clock);
      apbEnable = 1'b1;
      #1;
      while (!apbReady && !timedOut) begin
        if (waits >= readyLimit) begin
          $display("Timeout at %0t: apbReady stayed low for %0d cycles at offset 0x%02h",
                   $time, waits, addr);
          errorCount++;
          timedOut = 1'b1;
        end else begin
          waits++;
          @(negedge clock);
          #1;
        end
      end
      lastRdata  = apbRdata;
      lastSlvErr = apbSlvErr;
      lastWaits  = waits;
      @(negedge clock);                             // Transfer ended on the rising edge
      apbSel    = 1'b0;
      apbEnable = 1'b0;
      apbWrite  = 1'b0;
    end
  endtask

  task automatic writeReg(input heapConfigPkg::apbAddr_t addr,
                          input heapConfigPkg::apbWord_t data);
    busTransfer(1'b1, addr, data);
    if (addr != heapOpPkg::regCommand) begin
      checkValue($sformatf("wait cycles, write of 0x%02h", addr),
                 heapConfigPkg::apbWord_t'(lastWaits), '0);
      checkValue($sformatf("apbSlvErr, write of 0x%02h", addr),
                 heapConfigPkg::apbWord_t'(lastSlvErr), '0);
    end
  endtask

  task automatic readReg(input heapConfigPkg::apbAddr_t addr,
                         output heapConfigPkg::apbWord_t data);
    busTransfer(1'b0, addr, '0);
    data = lastRdata;
    checkValue($sformatf("wait cycles, read of 0x%02h", addr),
               heapConfigPkg::apbWord_t'(lastWaits), '0);
  endtask

  `include "heapTbTasks.svh"

  initial begin
    seed       = 26031;
    errorCount = 0;
    checkCount = 0;
    timedOut   = 1'b0;
    lastWaits  = 0;
    lastSlvErr = 1'b0;
    lastRdata  = '0;
    resetN     = 1'b0;
    apbSel     = 1'b0;
    apbEnable  = 1'b0;
    apbWrite   = 1'b0;
    apbAddr    = '0;
    apbWdata   = '0;
    resetModel();
    repeat (8) @(negedge clock);
    resetN = 1'b1;
    #1;
    testResetTiming();
    testAllocClear();
    testAccessChecks();
    testPushPop();
    testArithmetic();
    testFreeReuse();
    $display("Checks run: %0d, errors: %0d, timeouts: %0d",
             checkCount, errorCount, timedOut ? 1 : 0);
    if (errorCount == 0 && !timedOut) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
heapConfigPkg.sv
heapOpPkg.sv
heapApbDecode.sv
heapAllocator.sv
heapExecute.sv
heapResponse.sv
heapTop.sv
heapTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Builds the heap testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module heapTb -o heapSim
./obj_dir/heapSim | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "Testbench reported errors, see sim.log"
  exit 1
fi
echo "Run finished without reported errors"
